// File: include/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data path width
`define XLEN 32

// machine-mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// mstatus interrupt enable bits
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

// mpp stays at machine mode
`define MSTATUS_RESET 32'h0000_1800

// environment call from m-mode
`define CAUSE_ECALL 11

`endif

// File: hdl/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0] xlen_t;

    // decoded SYSTEM instruction class
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_MRET
    } sys_op_e;

    // csrs implemented by csr_file
    typedef enum logic [11:0] {
        ADDR_MSTATUS = `CSR_MSTATUS,
        ADDR_MTVEC   = `CSR_MTVEC,
        ADDR_MEPC    = `CSR_MEPC,
        ADDR_MCAUSE  = `CSR_MCAUSE
    } csr_addr_e;

endpackage

// File: hdl/csr_ctrl_if.sv
`timescale 1ns/1ps

interface csr_ctrl_if;

    csr_pkg::sys_op_e op;
    // raw csr field, may hold an unsupported address
    logic [11:0]      addr;
    logic             fire;
    logic             csr_we;
    logic             trap_take;
    logic             mret_take;
    csr_pkg::xlen_t   pc;

    modport ctrl (
        output op,
        output addr,
        output fire,
        output csr_we,
        output trap_take,
        output mret_take,
        output pc
    );

    modport regs (
        input op,
        input addr,
        input fire,
        input csr_we,
        input trap_take,
        input mret_take,
        input pc
    );

    // redirect only needs the take strobes
    modport redir (
        input fire,
        input trap_take,
        input mret_take,
        input op
    );

endinterface

// File: hdl/sys_decode.sv
`timescale 1ns/1ps

module sys_decode (
    input  logic [31:0]    instr_i,
    input  csr_pkg::xlen_t pc_i,
    input  logic           valid_i,
    input  logic           stall_n_i,
    csr_ctrl_if.ctrl       ctrl
);

    localparam logic [4:0]  OPC_SYSTEM = 5'b11100;
    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [2:0]  F3_CSRRS   = 3'b010;
    localparam logic [2:0]  F3_CSRRC   = 3'b011;
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_MRET   = 12'h302;

    logic        is_system;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign is_system = (instr_i[6:2] == OPC_SYSTEM);
    assign funct3    = instr_i[14:12];
    assign funct12   = instr_i[31:20];

    // csr field doubles as funct12
    assign ctrl.addr = funct12;
    assign ctrl.pc   = pc_i;

    always_comb begin
        ctrl.op = csr_pkg::OP_NONE;
        if (is_system) begin
            case (funct3)
                F3_CSRRW: ctrl.op = csr_pkg::OP_CSRRW;
                F3_CSRRS: ctrl.op = csr_pkg::OP_CSRRS;
                F3_CSRRC: ctrl.op = csr_pkg::OP_CSRRC;
                F3_PRIV: begin
                    if (funct12 == F12_ECALL) begin
                        ctrl.op = csr_pkg::OP_ECALL;
                    end else if (funct12 == F12_MRET) begin
                        ctrl.op = csr_pkg::OP_MRET;
                    end
                end
                // immediate forms are not supported
                default: ctrl.op = csr_pkg::OP_NONE;
            endcase
        end

        // accepted only when valid and not stalled
        ctrl.fire      = valid_i && stall_n_i;
        ctrl.csr_we    = ctrl.fire && (ctrl.op inside {csr_pkg::OP_CSRRW,
                                                       csr_pkg::OP_CSRRS,
                                                       csr_pkg::OP_CSRRC});
        ctrl.trap_take = ctrl.fire && (ctrl.op == csr_pkg::OP_ECALL);
        ctrl.mret_take = ctrl.fire && (ctrl.op == csr_pkg::OP_MRET);
    end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file (
    input  logic           clk,
    input  logic           rst_n,
    csr_ctrl_if.regs       ctrl,
    input  csr_pkg::xlen_t wdata_i,
    output csr_pkg::xlen_t rdata_o,
    output csr_pkg::xlen_t mtvec_o,
    output csr_pkg::xlen_t mepc_o
);

    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mcause;

    logic sel_mstatus;
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mcause;
    logic is_csr_op;

    csr_pkg::xlen_t csr_old;
    csr_pkg::xlen_t wr_val;
    csr_pkg::xlen_t mstatus_trap;
    csr_pkg::xlen_t mstatus_ret;

    // one-hot select, unknown address hits nothing
    assign sel_mstatus = (ctrl.addr == csr_pkg::ADDR_MSTATUS);
    assign sel_mtvec   = (ctrl.addr == csr_pkg::ADDR_MTVEC);
    assign sel_mepc    = (ctrl.addr == csr_pkg::ADDR_MEPC);
    assign sel_mcause  = (ctrl.addr == csr_pkg::ADDR_MCAUSE);

    assign is_csr_op = ctrl.op inside {csr_pkg::OP_CSRRW,
                                       csr_pkg::OP_CSRRS,
                                       csr_pkg::OP_CSRRC};

    assign csr_old = ({`XLEN{sel_mstatus}} & mstatus)
                   | ({`XLEN{sel_mtvec}}   & mtvec)
                   | ({`XLEN{sel_mepc}}    & mepc)
                   | ({`XLEN{sel_mcause}}  & mcause);

    // old value goes back to the pipeline, zero for non-csr ops
    assign rdata_o = is_csr_op ? csr_old : '0;

    // read-modify-write value
    always_comb begin
        case (ctrl.op)
            csr_pkg::OP_CSRRW: wr_val = wdata_i;
            csr_pkg::OP_CSRRS: wr_val = wdata_i | csr_old;
            csr_pkg::OP_CSRRC: wr_val = ~wdata_i & csr_old;
            default:           wr_val = csr_old;
        endcase
    end

    always_comb begin
        mstatus_trap = mstatus;
        mstatus_trap[`MSTATUS_MPIE] = mstatus[`MSTATUS_MIE];
        mstatus_trap[`MSTATUS_MIE]  = 1'b0;

        mstatus_ret = mstatus;
        mstatus_ret[`MSTATUS_MIE]  = mstatus[`MSTATUS_MPIE];
        mstatus_ret[`MSTATUS_MPIE] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= `MSTATUS_RESET;
        end else if (ctrl.trap_take) begin
            mstatus <= mstatus_trap;
        end else if (ctrl.mret_take) begin
            mstatus <= mstatus_ret;
        end else if (ctrl.csr_we && sel_mstatus) begin
            mstatus <= wr_val;
        end
    end

    // trap vector is word aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (ctrl.csr_we && sel_mtvec) begin
            mtvec <= {wr_val[`XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (ctrl.trap_take) begin
            mepc <= {ctrl.pc[`XLEN-1:2], 2'b00};
        end else if (ctrl.csr_we && sel_mepc) begin
            mepc <= {wr_val[`XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (ctrl.trap_take) begin
            mcause <= csr_pkg::xlen_t'(`CAUSE_ECALL);
        end else if (ctrl.csr_we && sel_mcause) begin
            mcause <= wr_val;
        end
    end

    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

    mtvec_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        mtvec[1:0] == 2'b00)
        else $error("mtvec lost its alignment");

    mepc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        mepc[1:0] == 2'b00)
        else $error("mepc lost its alignment");

endmodule

// File: hdl/trap_redirect.sv
`timescale 1ns/1ps

module trap_redirect (
    input  logic           clk,
    input  logic           rst_n,
    csr_ctrl_if.redir      ctrl,
    input  csr_pkg::xlen_t mtvec_i,
    input  csr_pkg::xlen_t mepc_i,
    output logic           redirect_o,
    output csr_pkg::xlen_t redirect_pc_o
);

    logic take_any;

    assign take_any = ctrl.trap_take || ctrl.mret_take;

    // single-cycle pulse per taken ecall or mret
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_o <= 1'b0;
        end else begin
            redirect_o <= take_any;
        end
    end

    // mepc is sampled before the mret retires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_pc_o <= '0;
        end else if (take_any) begin
            redirect_pc_o <= (ctrl.op == csr_pkg::OP_ECALL) ? mtvec_i : mepc_i;
        end
    end

    // back-to-back pulses need a fired take ahead of each
    redirect_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_o && $past(redirect_o))
        |-> ($past(ctrl.fire && take_any) && $past(ctrl.fire && take_any, 2)))
        else $error("redirect held high without a take behind it");

endmodule

// File: hdl/csr_trap_top.sv
`timescale 1ns/1ps

module csr_trap_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           valid_i,
    input  logic           stall_n_i,
    input  csr_pkg::xlen_t pc_i,
    input  logic [31:0]    instr_i,
    input  csr_pkg::xlen_t rs1_data_i,
    output csr_pkg::xlen_t csr_rdata_o,
    output logic           redirect_o,
    output csr_pkg::xlen_t redirect_pc_o
);

    csr_ctrl_if ctrl_if ();

    // trap targets from the csr file
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;

    sys_decode u_sys_decode (
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .valid_i   (valid_i),
        .stall_n_i (stall_n_i),
        .ctrl      (ctrl_if.ctrl)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl_if.regs),
        .wdata_i (rs1_data_i),
        .rdata_o (csr_rdata_o),
        .mtvec_o (mtvec),
        .mepc_o  (mepc)
    );

    trap_redirect u_trap_redirect (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl_if.redir),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: verification/csr_trap_tb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_trap_tb;

    localparam int          N_INSTR      = 2000;
    localparam int          RST_TIMEOUT  = 64;
    localparam int          FIRE_TIMEOUT = 64;
    localparam logic [11:0] ADDR_UNKNOWN = 12'h7c0;

    logic           clk;
    logic           rst_n;
    logic           valid_i;
    logic           stall_n_i;
    csr_pkg::xlen_t pc_i;
    logic [31:0]    instr_i;
    csr_pkg::xlen_t rs1_data_i;
    csr_pkg::xlen_t csr_rdata_o;
    logic           redirect_o;
    csr_pkg::xlen_t redirect_pc_o;

    // reference model of the csrs and the pending redirect
    csr_pkg::xlen_t m_mstatus;
    csr_pkg::xlen_t m_mtvec;
    csr_pkg::xlen_t m_mepc;
    csr_pkg::xlen_t m_mcause;
    logic           exp_redirect;
    csr_pkg::xlen_t exp_redirect_pc;
    logic [31:0]    lfsr;

    csr_trap_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .stall_n_i     (stall_n_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .csr_rdata_o   (csr_rdata_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic csr_pkg::sys_op_e op_from_sel(input logic [2:0] sel);
        case (sel)
            3'd0:       return csr_pkg::OP_NONE;
            3'd1, 3'd7: return csr_pkg::OP_CSRRW;
            3'd2, 3'd6: return csr_pkg::OP_CSRRS;
            3'd3:       return csr_pkg::OP_CSRRC;
            3'd4:       return csr_pkg::OP_ECALL;
            default:    return csr_pkg::OP_MRET;
        endcase
    endfunction

    function automatic logic [11:0] addr_from_sel(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return `CSR_MSTATUS;
            3'd1, 3'd6: return `CSR_MTVEC;
            3'd3:       return `CSR_MCAUSE;
            3'd4:       return ADDR_UNKNOWN;
            default:    return `CSR_MEPC;
        endcase
    endfunction

    // rs1 = x1, rd = x2; non-system ops become an addi
    function automatic logic [31:0] make_instr(input csr_pkg::sys_op_e op,
                                               input logic [11:0] addr);
        case (op)
            csr_pkg::OP_CSRRW: return {addr, 5'd1, 3'b001, 5'd2, 7'b1110011};
            csr_pkg::OP_CSRRS: return {addr, 5'd1, 3'b010, 5'd2, 7'b1110011};
            csr_pkg::OP_CSRRC: return {addr, 5'd1, 3'b011, 5'd2, 7'b1110011};
            csr_pkg::OP_ECALL: return 32'h0000_0073;
            csr_pkg::OP_MRET:  return 32'h3020_0073;
            default:           return {addr, 5'd1, 3'b000, 5'd2, 7'b0010011};
        endcase
    endfunction

    function automatic csr_pkg::xlen_t model_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input csr_pkg::xlen_t exp,
                              input csr_pkg::xlen_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected=%08h actual=%08h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_redirect(input logic exp_bit, input csr_pkg::xlen_t exp_pc);
        if (redirect_o !== exp_bit) begin
            $display("FAIL t=%0t redirect_o expected=%0b actual=%0b", $time, exp_bit,
                     redirect_o);
            $display("TESTS FAILED");
            $fatal(1);
        end else begin
            check_word("redirect_pc_o", exp_pc, redirect_pc_o);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s did not happen in time at t=%0t", what, $time);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // applies one accepted instruction to the model
    task automatic model_update(input csr_pkg::sys_op_e op, input logic [11:0] addr,
                                input csr_pkg::xlen_t pc, input csr_pkg::xlen_t rs1);
        csr_pkg::xlen_t old_val;
        csr_pkg::xlen_t new_val;
        old_val = model_read(addr);
        exp_redirect = 1'b0;
        case (op)
            csr_pkg::OP_CSRRW: new_val = rs1;
            csr_pkg::OP_CSRRS: new_val = old_val | rs1;
            csr_pkg::OP_CSRRC: new_val = old_val & ~rs1;
            default:           new_val = old_val;
        endcase
        if (op == csr_pkg::OP_ECALL) begin
            exp_redirect    = 1'b1;
            exp_redirect_pc = m_mtvec;
            m_mepc          = {pc[`XLEN-1:2], 2'b00};
            m_mcause        = `CAUSE_ECALL;
            m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
            m_mstatus[`MSTATUS_MIE]  = 1'b0;
        end else if (op == csr_pkg::OP_MRET) begin
            exp_redirect    = 1'b1;
            exp_redirect_pc = m_mepc;
            m_mstatus[`MSTATUS_MIE]  = m_mstatus[`MSTATUS_MPIE];
            m_mstatus[`MSTATUS_MPIE] = 1'b1;
        end else if (op != csr_pkg::OP_NONE) begin
            case (addr)
                `CSR_MSTATUS: m_mstatus = new_val;
                `CSR_MTVEC:   m_mtvec   = {new_val[`XLEN-1:2], 2'b00};
                `CSR_MEPC:    m_mepc    = {new_val[`XLEN-1:2], 2'b00};
                `CSR_MCAUSE:  m_mcause  = new_val;
                default:      ;
            endcase
        end
    endtask

    // drive after the edge, check at the falling edge
    task automatic apply_cycle(input csr_pkg::sys_op_e op, input logic [11:0] addr,
                               input csr_pkg::xlen_t pc, input csr_pkg::xlen_t rs1,
                               input logic valid, input logic stall_n, output logic fired);
        csr_pkg::xlen_t exp_rdata;
        @(posedge clk);
        #1;
        valid_i    = valid;
        stall_n_i  = stall_n;
        pc_i       = pc;
        instr_i    = make_instr(op, addr);
        rs1_data_i = rs1;
        @(negedge clk);
        exp_rdata = '0;
        if (op inside {csr_pkg::OP_CSRRW, csr_pkg::OP_CSRRS, csr_pkg::OP_CSRRC}) begin
            exp_rdata = model_read(addr);
        end
        check_word("csr_rdata_o", exp_rdata, csr_rdata_o);
        check_redirect(exp_redirect, exp_redirect_pc);
        fired = valid && stall_n;
        if (fired) begin
            model_update(op, addr, pc, rs1);
        end else begin
            exp_redirect = 1'b0;
        end
    endtask

    initial begin
        csr_pkg::sys_op_e op;
        logic [11:0]      addr;
        csr_pkg::xlen_t   pc;
        csr_pkg::xlen_t   rs1;
        logic [31:0]      bits;
        logic             valid;
        logic             stall_n;
        logic             fired;
        int               waited;

        lfsr       = 32'd91200;
        valid_i    = 1'b0;
        stall_n_i  = 1'b1;
        pc_i       = '0;
        instr_i    = '0;
        rs1_data_i = '0;
        m_mstatus  = `MSTATUS_RESET;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > RST_TIMEOUT) begin
                report_timeout("reset release");
            end
        end

        // reset values, read without firing
        for (int i = 0; i < 4; i++) begin
            apply_cycle(csr_pkg::OP_CSRRS, addr_from_sel(i[2:0]), '0, '0, 1'b0, 1'b1, fired);
        end

        for (int n = 0; n < N_INSTR; n++) begin
            bits = draw_bits(3);
            op   = op_from_sel(bits[2:0]);
            bits = draw_bits(3);
            addr = addr_from_sel(bits[2:0]);
            rs1  = draw_bits(32);
            pc   = draw_bits(32);
            waited = 0;
            fired  = 1'b0;
            // instruction is held until it is accepted
            while (!fired) begin
                valid   = (draw_bits(3) != 0);
                stall_n = (draw_bits(2) != 0);
                apply_cycle(op, addr, pc, rs1, valid, stall_n, fired);
                waited++;
                if (!fired && waited >= FIRE_TIMEOUT) begin
                    report_timeout("instruction acceptance");
                end
            end
        end

        // one idle cycle to see the last redirect
        apply_cycle(csr_pkg::OP_NONE, '0, '0, '0, 1'b0, 1'b1, fired);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_ctrl_if.sv
hdl/sys_decode.sv
hdl/csr_file.sv
hdl/trap_redirect.sv
hdl/csr_trap_top.sv
verification/csr_trap_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module csr_trap_tb
	./obj_dir/Vcsr_trap_tb 2>&1 | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
